// ==== vlog.f ====
+incdir+design
design/lift_pkg.sv
design/call_if.sv
design/call_search.sv
design/car_motion.sv
design/lift_controller.sv
bench/lift_tb.sv

// ==== bench/lift_tb.sv ====
`default_nettype none

`include "lift_defines.svh"

module lift_tb import lift_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // six short tests with a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic           clk;
    logic           reset;
    floor_mask_t    car_req;
    floor_mask_t    up_req;      // bit 4 stays clear
    floor_mask_t    down_req;    // bit 0 stays clear
    motion_dir_t    dir;
    floor_t         target_floor;
    floor_t         floor;

    logic           idle;
    logic           quiet;       // test 1 window
    search_result_t model_res;   // expected next stop in the current direction

    int             errors;
    int             failed_tests;
    int             test_no;
    int             errors_at_start;
    int             cycles;
    logic [31:0]    rng;
    logic           was_moving;
    logic           last_up;
    floor_t         rest_log[$];

    lift_controller lift_controller_i (
        .clk          (clk),
        .reset        (reset),
        .car_call     (car_req),
        .hall_up      (up_req[3:0]),
        .hall_down    (down_req[4:1]),
        .dir          (dir),
        .target_floor (target_floor),
        .floor        (floor)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, requests were left unserved", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // nearest call served in this direction, else the farthest turnaround call
    function automatic search_result_t expected_stop(input floor_mask_t car,
        input floor_mask_t up, input floor_mask_t down, input floor_t f, input bit going_up);
        search_result_t r;
        int fl;
        int turn;
        r = '0;
        turn = -1;
        for (int d = 1; d < `LIFT_FLOORS; d++) begin
            fl = going_up ? int'(f) + d : int'(f) - d;
            if (fl >= 0 && fl < `LIFT_FLOORS) begin
                if (!r.found && (car[fl] || (going_up ? up[fl] : down[fl]))) begin
                    r.found = 1'b1;
                    r.stop  = floor_t'(fl);
                end
                if (going_up ? down[fl] : up[fl]) begin
                    turn = fl;   // later hits lie farther out
                end
            end
        end
        if (!r.found && turn >= 0) begin
            r.found = 1'b1;
            r.stop  = floor_t'(turn);
        end
        return r;
    endfunction

    function automatic bit pending();
        return |(car_req | up_req | down_req);
    endfunction

    function automatic string log_text();
        string s;
        s = "";
        foreach (rest_log[i]) begin
            if (i > 0) begin
                s = {s, " "};
            end
            s = {s, $sformatf("%0d", rest_log[i])};
        end
        return s;
    endfunction

    assign idle      = (car_req | up_req | down_req) == '0;
    assign model_res = expected_stop(car_req, up_req, down_req, floor, dir == DIR_UP);

    task automatic report_error(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic raise_calls(input floor_mask_t car, input floor_mask_t up,
                               input floor_mask_t down);
        car_req  = car_req | car;
        up_req   = up_req | (up & 5'b01111);
        down_req = down_req | (down & 5'b11110);
    endtask

    // one falling edge where passengers leave a car resting at their floor
    task automatic step();
        int f;
        @(negedge clk);
        f = int'(floor);
        if (dir != DIR_STAY) begin
            was_moving = 1'b1;
            last_up    = (dir == DIR_UP);
        end else begin
            if (was_moving) begin
                rest_log.push_back(floor);
                was_moving = 1'b0;
            end
            if (car_req[f] || up_req[f] || down_req[f]) begin
                car_req[f] = 1'b0;
                if (last_up && up_req[f]) begin
                    up_req[f] = 1'b0;
                end else if (!last_up && down_req[f]) begin
                    down_req[f] = 1'b0;
                end else begin
                    up_req[f]   = 1'b0;
                    down_req[f] = 1'b0;
                end
            end
        end
    endtask

    task automatic serve_all();
        do begin
            step();
        end while (pending() || dir != DIR_STAY);
    endtask

    task automatic check_rests(input string expected, input string what);
        rest_order_a: assert (log_text() == expected)
            else report_error($sformatf("%s rested at %s, expected %s",
                                        what, log_text(), expected));
        rest_log.delete();
    endtask

    task automatic start_test();
        errors_at_start = errors;
        rest_log.delete();
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_no, name, errors - errors_at_start);
        end
    endtask

    settle_a: assert property (@(posedge clk) disable iff (reset)
        quiet |-> floor == '0 && dir == DIR_STAY && target_floor == '0)
        else report_error("car left floor 0 or target moved without requests");

    shaft_a: assert property (@(posedge clk) disable iff (reset)
        !(dir == DIR_UP && floor == floor_t'(`LIFT_FLOORS - 1)) &&
        !(dir == DIR_DOWN && floor == '0))
        else report_error($sformatf("dir %s at floor %0d", dir.name(), floor));

    step_a: assert property (@(posedge clk) disable iff (reset)
        $changed(floor) |-> floor == floor_t'($past(floor) + 1) ||
                            floor == floor_t'($past(floor) - 1))
        else report_error($sformatf("floor jumped to %0d", floor));

    // each hop with requests pending is three cycles of one nonzero direction
    hop_a: assert property (@(posedge clk) disable iff (reset)
        ($changed(floor) && !$past(idle, 2) && !$past(idle, 3) && !$past(idle, 4)) |->
            $past(dir) != DIR_STAY &&
            $past(dir, 2) == $past(dir) && $past(dir, 3) == $past(dir) &&
            $past(floor, 2) == $past(floor) && $past(floor, 3) == $past(floor))
        else report_error($sformatf("short hop into floor %0d", floor));

    hop_len_a: assert property (@(posedge clk) disable iff (reset)
        ($past(dir) != DIR_STAY && $past(dir, 2) != DIR_STAY &&
         $past(dir, 3) != DIR_STAY && $past(floor, 3) == $past(floor)) |-> $changed(floor))
        else report_error($sformatf("hop from floor %0d too long", $past(floor)));

    idle_a: assert property (@(posedge clk) disable iff (reset)
        idle |=> dir == DIR_STAY)
        else report_error($sformatf("dir %s with no requests", dir.name()));

    target_a: assert property (@(posedge clk) disable iff (reset)
        ($past(dir) != DIR_STAY && $past(model_res.found)) |->
            target_floor == $past(model_res.stop))
        else report_error($sformatf("target %0d, expected %0d",
                                    target_floor, $past(model_res.stop)));

    rest_a: assert property (@(posedge clk) disable iff (reset)
        ($past(dir) != DIR_STAY && dir == DIR_STAY && !$past(idle) &&
         $past(model_res.found)) |-> floor == $past(model_res.stop))
        else report_error($sformatf("rested at %0d, next stop was %0d",
                                    floor, $past(model_res.stop)));

    initial begin
        car_req      = '0;
        up_req       = '0;
        down_req     = '0;
        reset        = 1'b1;
        quiet        = 1'b0;
        errors       = 0;
        failed_tests = 0;
        test_no      = 0;
        cycles       = 0;
        rng          = 32'd81070;
        was_moving   = 1'b0;
        last_up      = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        start_test();
        quiet = 1'b1;
        repeat (20) @(negedge clk);
        quiet = 1'b0;
        finish_test("idle after reset");

        start_test();
        raise_calls(5'b01000, '0, '0);
        serve_all();
        check_rests("3", "car call to 3");
        raise_calls(5'b00010, '0, '0);
        serve_all();
        check_rests("1", "car call to 1");
        finish_test("single car calls");

        start_test();
        raise_calls(5'b00001, '0, '0);
        serve_all();
        rest_log.delete();
        raise_calls(5'b10000, 5'b00100, '0);   // hall up at 2 is on the way
        serve_all();
        check_rests("2 4", "hall up at 2");
        raise_calls(5'b00001, '0, '0);
        serve_all();
        rest_log.delete();
        raise_calls(5'b10000, '0, 5'b00100);   // hall down at 2 is passed
        serve_all();
        check_rests("4 2", "hall down at 2");
        finish_test("collective stopping");

        start_test();
        raise_calls(5'b00001, '0, '0);
        serve_all();
        raise_calls(5'b00100, '0, '0);
        serve_all();
        rest_log.delete();
        raise_calls(5'b10001, '0, '0);
        serve_all();
        check_rests("4 0", "calls at 0 and 4 from 2");
        finish_test("direction preference");

        start_test();
        raise_calls(5'b10000, '0, 5'b01000);
        repeat (2) step();
        raise_calls('0, 5'b00100, 5'b00010);   // added during the first hop
        serve_all();
        check_rests("2 4 3 1", "mixed calls");
        // every request withdrawn in the middle of the hop from 1
        raise_calls(5'b01000, '0, '0);
        repeat (2) step();
        car_req  = '0;
        up_req   = '0;
        down_req = '0;
        while (floor == 3'd1) begin
            step();
        end
        withdraw_a: assert (floor == 3'd2 && dir == DIR_STAY)
            else report_error($sformatf("car at %0d with dir %s after withdrawal",
                                        floor, dir.name()));
        rest_log.delete();
        finish_test("target tracking");

        start_test();
        for (int round = 0; round < 10; round++) begin
            rng = xorshift32(rng);
            raise_calls(rng[4:0], rng[12:8], rng[20:16]);
            repeat (5) step();
            rng = xorshift32(rng);
            raise_calls(rng[4:0], rng[12:8], rng[20:16]);
            serve_all();
        end
        finish_test("random passengers");

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 test_no, failed_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/lift_controller.sv ====
`default_nettype none

`include "lift_defines.svh"

module lift_controller import lift_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`LIFT_FLOORS-1:0]  car_call,
    input  wire [`LIFT_FLOORS-2:0]  hall_up,     // floors 0 to 3
    input  wire [`LIFT_FLOORS-2:0]  hall_down,   // floors 1 to 4
    output motion_dir_t             dir,
    output floor_t                  target_floor,
    output floor_t                  floor
);

    search_result_t above;
    search_result_t below;

    call_if calls_if ();

    assign calls_if.car_calls = car_call;
    assign calls_if.hall_up   = {1'b0, hall_up};     // no up call at the top
    assign calls_if.hall_down = {hall_down, 1'b0};   // no down call at the bottom

    assign floor = calls_if.floor;

    call_search #(
        .search_up (1'b1)
    ) up_search_i (
        .calls  (calls_if),
        .result (above)
    );

    call_search #(
        .search_up (1'b0)
    ) down_search_i (
        .calls  (calls_if),
        .result (below)
    );

    car_motion car_motion_i (
        .clk          (clk),
        .reset        (reset),
        .calls        (calls_if),
        .above        (above),
        .below        (below),
        .dir          (dir),
        .target_floor (target_floor)
    );

endmodule

`default_nettype wire

// ==== design/car_motion.sv ====
`default_nettype none

`include "lift_defines.svh"

module car_motion import lift_pkg::*; (
    input  var bit              clk,
    input  var bit              reset,
    call_if.motion              calls,
    input  wire search_result_t above,
    input  wire search_result_t below,
    output motion_dir_t         dir,
    output floor_t              target_floor
);

    localparam int unsigned TOP_FLOOR = `LIFT_FLOORS - 1;
    localparam int unsigned CNT_W     = $clog2(`LIFT_TRAVEL_CYCLES + 1);

    typedef enum logic {
        RESTING,
        TRAVELLING
    } motion_state_t;

    motion_state_t    state;
    motion_state_t    state_nxt;
    floor_t           floor_q;
    floor_t           floor_nxt;
    logic [CNT_W-1:0] hop_cnt;
    logic [CNT_W-1:0] hop_cnt_nxt;
    logic             last_up;      // last direction moved, up after reset
    logic             last_up_nxt;
    motion_dir_t      dir_nxt;
    floor_t           target_nxt;

    floor_mask_t      all_calls;
    logic             at_floor;
    logic             idle;
    logic             hop_done;
    search_result_t   ahead;
    floor_t           next_floor;

    assign all_calls  = calls.car_calls | calls.hall_up | calls.hall_down;
    assign at_floor   = all_calls[floor_q];
    assign idle       = ~|all_calls;
    assign ahead      = last_up ? above : below;   // search taken from the hop's start floor
    assign hop_done   = (state == TRAVELLING) && (hop_cnt == CNT_W'(`LIFT_TRAVEL_CYCLES - 1));
    assign next_floor = last_up ? floor_q + 1'b1 : floor_q - 1'b1;

    assign calls.floor = floor_q;

    always_comb begin
        state_nxt   = state;
        floor_nxt   = floor_q;
        hop_cnt_nxt = hop_cnt;
        last_up_nxt = last_up;
        dir_nxt     = DIR_STAY;
        target_nxt  = floor_q;

        case (state)
            RESTING: begin
                // a request here keeps the doors open
                if (!at_floor && above.found && (last_up || !below.found)) begin
                    state_nxt   = TRAVELLING;
                    hop_cnt_nxt = '0;
                    last_up_nxt = 1'b1;
                    dir_nxt     = DIR_UP;
                    target_nxt  = above.stop;
                end else if (!at_floor && below.found) begin
                    state_nxt   = TRAVELLING;
                    hop_cnt_nxt = '0;
                    last_up_nxt = 1'b0;
                    dir_nxt     = DIR_DOWN;
                    target_nxt  = below.stop;
                end
            end
            TRAVELLING: begin
                dir_nxt    = last_up ? DIR_UP : DIR_DOWN;
                target_nxt = ahead.stop;
                if (hop_done) begin
                    floor_nxt   = next_floor;
                    hop_cnt_nxt = '0;
                    if (!ahead.found || ahead.stop == next_floor) begin
                        state_nxt  = RESTING;
                        dir_nxt    = DIR_STAY;
                        target_nxt = next_floor;
                    end
                end else begin
                    hop_cnt_nxt = hop_cnt + 1'b1;
                end
            end
            default: begin
                state_nxt = RESTING;
            end
        endcase

        // no requests at all, report stay while the hop runs out
        if (idle) begin
            dir_nxt = DIR_STAY;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= RESTING;
            floor_q      <= '0;
            hop_cnt      <= '0;
            last_up      <= 1'b1;
            dir          <= DIR_STAY;
            target_floor <= '0;
        end else begin
            state        <= state_nxt;
            floor_q      <= floor_nxt;
            hop_cnt      <= hop_cnt_nxt;
            last_up      <= last_up_nxt;
            dir          <= dir_nxt;
            target_floor <= target_nxt;
        end
    end

    shaft_limits_a: assert property (@(posedge clk) disable iff (reset)
        !(dir == DIR_UP && floor_q == floor_t'(TOP_FLOOR)) &&
        !(dir == DIR_DOWN && floor_q == '0))
        else $error("car_motion: dir %s at floor %0d", dir.name(), floor_q);

    // floor moves one step, only at the end of a hop
    floor_step_a: assert property (@(posedge clk) disable iff (reset)
        $changed(floor_q) |-> $past(hop_done) &&
            (floor_q == floor_t'($past(floor_q) + 1'b1) ||
             floor_q == floor_t'($past(floor_q) - 1'b1)))
        else $error("car_motion: floor jumped to %0d", floor_q);

endmodule

`default_nettype wire

// ==== design/call_search.sv ====
`default_nettype none

`include "lift_defines.svh"

module call_search import lift_pkg::*; #(
    parameter bit search_up = 1'b1
) (
    call_if.search         calls,
    output search_result_t result
);

    floor_mask_t beyond;      // floors strictly past the car
    floor_mask_t stop_mask;   // requests served on the way
    floor_mask_t pass_mask;   // opposite hall calls, only taken as the turnaround

    function automatic floor_t lowest_set(floor_mask_t m);
        floor_t idx;
        idx = '0;
        for (int i = `LIFT_FLOORS - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = floor_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic floor_t highest_set(floor_mask_t m);
        floor_t idx;
        idx = '0;
        for (int i = 0; i < `LIFT_FLOORS; i++) begin
            if (m[i]) begin
                idx = floor_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < `LIFT_FLOORS; i++) begin
            beyond[i] = search_up ? (i > calls.floor) : (i < calls.floor);
        end
    end

    assign stop_mask = beyond & (calls.car_calls | (search_up ? calls.hall_up : calls.hall_down));
    assign pass_mask = beyond & (search_up ? calls.hall_down : calls.hall_up);

    always_comb begin
        result.found = |{stop_mask, pass_mask};
        if (|stop_mask) begin
            // nearest one in the direction of travel
            result.stop = search_up ? lowest_set(stop_mask) : highest_set(stop_mask);
        end else begin
            // farthest reverse call, the car turns there
            result.stop = search_up ? highest_set(pass_mask) : lowest_set(pass_mask);
        end
    end

    always_comb begin
        if (result.found) begin
            stop_ahead_a: assert #0 (result.stop < `LIFT_FLOORS &&
                (search_up ? result.stop > calls.floor : result.stop < calls.floor))
                else $error("call_search: stop %0d not beyond floor %0d",
                            result.stop, calls.floor);
        end
    end

endmodule

`default_nettype wire

// ==== design/call_if.sv ====
`default_nettype none

interface call_if import lift_pkg::*; ();

    floor_mask_t car_calls;
    floor_mask_t hall_up;     // top floor bit always clear
    floor_mask_t hall_down;   // ground floor bit always clear
    floor_t      floor;

    modport search (
        input car_calls,
        input hall_up,
        input hall_down,
        input floor
    );

    modport motion (
        input  car_calls,
        input  hall_up,
        input  hall_down,
        output floor
    );

endinterface

`default_nettype wire

// ==== design/lift_pkg.sv ====
`default_nettype none

`include "lift_defines.svh"

package lift_pkg;

    typedef logic [`LIFT_FLOOR_W-1:0] floor_t;

    // bit i is floor i
    typedef logic [`LIFT_FLOORS-1:0] floor_mask_t;

    // motion for the next cycle
    typedef enum logic [1:0] {
        DIR_STAY = 2'b00,
        DIR_DOWN = 2'b01,
        DIR_UP   = 2'b10
    } motion_dir_t;

    // outcome of one directional request scan
    typedef struct packed {
        logic   found;
        floor_t stop;
    } search_result_t;

endpackage

`default_nettype wire

// ==== design/lift_defines.svh ====
`ifndef LIFT_DEFINES_SVH
`define LIFT_DEFINES_SVH

// shaft size
`define LIFT_FLOORS 5
`define LIFT_FLOOR_W 3

// clock cycles for one floor-to-floor hop
`define LIFT_TRAVEL_CYCLES 3

`endif
